/* source/xr_defines.svh */
`ifndef XR_DEFINES_SVH
`define XR_DEFINES_SVH

// colour lookup RAM address width, one RAM per playfield
`define XR_COLOR_W      8

// tile region address width, top bit picks the second tile RAM
`define XR_TILE_W       11

// second tile RAM address width, higher addresses alias
`define XR_TILE2_W      9

// copper program address width in 32-bit longwords
`define XR_COPP_W       8

// implemented configuration registers and register-bus address width
`define XR_REGS_N       8
`define XR_REG_AW       7

// region codes, taken from XR address bits 15:14
`define XR_REGION_REGS  2'd0
`define XR_REGION_TILE  2'd1
`define XR_REGION_COLOR 2'd2
`define XR_REGION_COPP  2'd3

`endif

/* source/xr_pkg.sv */
`default_nettype none

`include "xr_defines.svh"

package xr_pkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;
    typedef logic [15:0] argb_t;

    typedef logic [`XR_COLOR_W-1:0] color_addr_t;
    typedef logic [`XR_TILE_W-1:0]  tile_addr_t;
    typedef logic [`XR_COPP_W-1:0]  copp_addr_t;

    // even word in the high half, odd word in the low half
    typedef logic [31:0] copp_word_t;

    typedef enum logic [1:0] {
        REGION_REGS  = `XR_REGION_REGS,
        REGION_TILE  = `XR_REGION_TILE,
        REGION_COLOR = `XR_REGION_COLOR,
        REGION_COPP  = `XR_REGION_COPP
    } xr_region_e;

    typedef struct packed {
        logic  wr;
        addr_t addr;
        word_t data;
    } xr_req_t;

    // copper only writes
    typedef struct packed {
        addr_t addr;
        word_t data;
    } copp_wr_t;

    typedef struct packed {
        color_addr_t a_addr;
        color_addr_t b_addr;
    } vgen_color_req_t;

    typedef struct packed {
        argb_t a_data;
        argb_t b_data;
    } color_pair_t;

    typedef struct packed {
        logic                  wr;
        logic [`XR_REG_AW-1:0] addr;
        word_t                 data;
    } xreg_bus_t;

    // regs[0] sits in the low 16 bits
    typedef struct packed {
        word_t [`XR_REGS_N-1:0] regs;
    } xr_cfg_t;

endpackage

`default_nettype wire

/* source/xr_bram.sv */
`default_nettype none

module xr_bram #(
    parameter int  AWIDTH = 8,
    parameter type data_t = logic [15:0]
) (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire logic              wr_en_i,
    input  wire logic [AWIDTH-1:0] wr_addr_i,
    input  wire logic [AWIDTH-1:0] rd_addr_i,
    input  wire data_t             wr_data_i,
    output      data_t             rd_data_o
);

    localparam int DEPTH = 2 ** AWIDTH;

    data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // read sees the old word when the same address is written this cycle
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

    // an unknown write address would corrupt an unpredictable word
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wr_en_i |-> !$isunknown(wr_addr_i)
    );

endmodule

`default_nettype wire

/* source/xr_config_regs.sv */
`default_nettype none

`include "xr_defines.svh"

module xr_config_regs (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire xr_pkg::xreg_bus_t xreg_i,
    output      xr_pkg::word_t     xreg_data_o,
    output      xr_pkg::xr_cfg_t   cfg_o
);

    import xr_pkg::*;

    localparam int IDX_W = $clog2(`XR_REGS_N);

    xr_cfg_t          cfg_q;
    logic             in_range;
    logic [IDX_W-1:0] idx;

    // only the first XR_REGS_N addresses are implemented
    assign in_range = (xreg_i.addr < `XR_REGS_N);
    assign idx      = xreg_i.addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cfg_q <= '0;
        end else if (xreg_i.wr && in_range) begin
            cfg_q.regs[idx] <= xreg_i.data;
        end
    end

    // sampled every cycle, so the arbiter finds the word in its ack cycle
    always_ff @(posedge clk) begin
        if (in_range) begin
            xreg_data_o <= cfg_q.regs[idx];
        end else begin
            xreg_data_o <= '0;
        end
    end

    assign cfg_o = cfg_q;

endmodule

`default_nettype wire

/* source/xrmem_arb.sv */
`default_nettype none

`include "xr_defines.svh"

module xrmem_arb (
    input  wire logic                    clk,
    input  wire logic                    rst_n_i,
    // host port, read and write
    input  wire logic                    xr_sel_i,
    input  wire xr_pkg::xr_req_t         xr_req_i,
    output      logic                    xr_ack_o,
    output      xr_pkg::word_t           xr_data_o,
    // copper port, write only
    input  wire logic                    copp_sel_i,
    input  wire xr_pkg::copp_wr_t        copp_wr_i,
    output      logic                    copp_ack_o,
    // register bus
    output      xr_pkg::xreg_bus_t       xreg_o,
    input  wire xr_pkg::word_t           xreg_data_i,
    // video and copper read ports
    input  wire logic                    vgen_color_sel_i,
    input  wire xr_pkg::vgen_color_req_t vgen_color_addr_i,
    output      xr_pkg::color_pair_t     color_data_o,
    input  wire logic                    vgen_tile_sel_i,
    input  wire xr_pkg::tile_addr_t      vgen_tile_addr_i,
    output      xr_pkg::word_t           tile_data_o,
    input  wire logic                    copp_prog_sel_i,
    input  wire xr_pkg::copp_addr_t      copp_prog_addr_i,
    output      xr_pkg::copp_word_t      copp_prog_data_o
);

    import xr_pkg::*;

    xr_region_e  host_region;
    xr_region_e  copp_region;
    xr_region_e  wr_region;
    logic        host_go;
    logic        host_rd;
    logic        regs_host_rd;
    logic        color_host_rd;
    logic        tile_host_rd;
    logic        copp_host_rd;
    logic        host_accept;
    logic        copp_accept;
    logic        wr_en;
    addr_t       wr_addr;
    word_t       wr_data;
    logic        color_wr;
    logic        tile_wr;
    logic        copp_wr;
    color_addr_t color_a_rd_addr;
    color_addr_t color_b_rd_addr;
    tile_addr_t  tile_rd_addr;
    copp_addr_t  copp_rd_addr;
    argb_t       color_a_data;
    argb_t       color_b_data;
    word_t       tile_data;
    word_t       tile2_data;
    word_t       copp_even_data;
    word_t       copp_odd_data;
    logic        tile_bank_q;
    xr_region_e  rd_region_q;
    logic        rd_hi_q;

    assign host_region = xr_region_e'(xr_req_i.addr[15:14]);
    assign copp_region = xr_region_e'(copp_wr_i.addr[15:14]);

    // host waits while the copper selects or a reader owns the target RAM
    assign host_go       = xr_sel_i & ~xr_ack_o & ~copp_sel_i;
    assign host_rd       = host_go & ~xr_req_i.wr;
    assign regs_host_rd  = host_rd & (host_region == REGION_REGS);
    assign color_host_rd = host_rd & (host_region == REGION_COLOR) & ~vgen_color_sel_i;
    assign tile_host_rd  = host_rd & (host_region == REGION_TILE) & ~vgen_tile_sel_i;
    assign copp_host_rd  = host_rd & (host_region == REGION_COPP) & ~copp_prog_sel_i;

    assign host_accept = (host_go & xr_req_i.wr) | regs_host_rd | color_host_rd
                       | tile_host_rd | copp_host_rd;
    assign copp_accept = copp_sel_i & ~copp_ack_o;

    // single write source, copper wins
    assign wr_addr   = copp_sel_i ? copp_wr_i.addr : xr_req_i.addr;
    assign wr_data   = copp_sel_i ? copp_wr_i.data : xr_req_i.data;
    assign wr_region = copp_sel_i ? copp_region : host_region;
    assign wr_en     = copp_accept | (host_accept & xr_req_i.wr);

    assign color_wr = wr_en & (wr_region == REGION_COLOR);
    assign tile_wr  = wr_en & (wr_region == REGION_TILE);
    assign copp_wr  = wr_en & (wr_region == REGION_COPP);

    // address also serves host register reads, answered next cycle
    assign xreg_o = '{
        wr:   wr_en & (wr_region == REGION_REGS),
        addr: wr_addr[`XR_REG_AW-1:0],
        data: wr_data
    };

    // shared read addresses go to the host only while it reads that RAM
    always_comb begin
        color_a_rd_addr = vgen_color_addr_i.a_addr;
        color_b_rd_addr = vgen_color_addr_i.b_addr;
        if (color_host_rd) begin
            color_a_rd_addr = xr_req_i.addr[`XR_COLOR_W-1:0];
            color_b_rd_addr = xr_req_i.addr[`XR_COLOR_W-1:0];
        end
    end

    assign tile_rd_addr = tile_host_rd ? xr_req_i.addr[`XR_TILE_W-1:0] : vgen_tile_addr_i;
    assign copp_rd_addr = copp_host_rd ? xr_req_i.addr[`XR_COPP_W:1] : copp_prog_addr_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            xr_ack_o    <= 1'b0;
            copp_ack_o  <= 1'b0;
            tile_bank_q <= 1'b0;
            rd_region_q <= REGION_REGS;
            rd_hi_q     <= 1'b0;
        end else begin
            xr_ack_o    <= host_accept;
            copp_ack_o  <= copp_accept;
            tile_bank_q <= tile_rd_addr[`XR_TILE_W-1];
            if (host_accept) begin
                rd_region_q <= host_region;
                // playfield B for colour, odd word for copper
                if (host_region == REGION_COPP) begin
                    rd_hi_q <= xr_req_i.addr[0];
                end else begin
                    rd_hi_q <= xr_req_i.addr[`XR_COLOR_W];
                end
            end
        end
    end

    assign color_data_o     = '{a_data: color_a_data, b_data: color_b_data};
    assign tile_data_o      = tile_bank_q ? tile2_data : tile_data;
    assign copp_prog_data_o = {copp_even_data, copp_odd_data};

    always_comb begin
        case (rd_region_q)
            REGION_COLOR: xr_data_o = rd_hi_q ? color_b_data : color_a_data;
            REGION_TILE:  xr_data_o = tile_data_o;
            REGION_COPP:  xr_data_o = rd_hi_q ? copp_odd_data : copp_even_data;
            default:      xr_data_o = xreg_data_i;
        endcase
    end

    xr_bram #(.AWIDTH(`XR_COLOR_W), .data_t(argb_t)) i_color_a (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (color_wr & ~wr_addr[`XR_COLOR_W]),
        .wr_addr_i (wr_addr[`XR_COLOR_W-1:0]),
        .rd_addr_i (color_a_rd_addr),
        .wr_data_i (wr_data),
        .rd_data_o (color_a_data)
    );

    xr_bram #(.AWIDTH(`XR_COLOR_W), .data_t(argb_t)) i_color_b (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (color_wr & wr_addr[`XR_COLOR_W]),
        .wr_addr_i (wr_addr[`XR_COLOR_W-1:0]),
        .rd_addr_i (color_b_rd_addr),
        .wr_data_i (wr_data),
        .rd_data_o (color_b_data)
    );

    xr_bram #(.AWIDTH(`XR_TILE_W-1), .data_t(word_t)) i_tile (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (tile_wr & ~wr_addr[`XR_TILE_W-1]),
        .wr_addr_i (wr_addr[`XR_TILE_W-2:0]),
        .rd_addr_i (tile_rd_addr[`XR_TILE_W-2:0]),
        .wr_data_i (wr_data),
        .rd_data_o (tile_data)
    );

    // smaller bank, upper address bits alias
    xr_bram #(.AWIDTH(`XR_TILE2_W), .data_t(word_t)) i_tile2 (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (tile_wr & wr_addr[`XR_TILE_W-1]),
        .wr_addr_i (wr_addr[`XR_TILE2_W-1:0]),
        .rd_addr_i (tile_rd_addr[`XR_TILE2_W-1:0]),
        .wr_data_i (wr_data),
        .rd_data_o (tile2_data)
    );

    xr_bram #(.AWIDTH(`XR_COPP_W), .data_t(word_t)) i_copp_even (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (copp_wr & ~wr_addr[0]),
        .wr_addr_i (wr_addr[`XR_COPP_W:1]),
        .rd_addr_i (copp_rd_addr),
        .wr_data_i (wr_data),
        .rd_data_o (copp_even_data)
    );

    xr_bram #(.AWIDTH(`XR_COPP_W), .data_t(word_t)) i_copp_odd (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (copp_wr & wr_addr[0]),
        .wr_addr_i (wr_addr[`XR_COPP_W:1]),
        .rd_addr_i (copp_rd_addr),
        .wr_data_i (wr_data),
        .rd_data_o (copp_odd_data)
    );

    a_xr_ack_pulse: assert property (
        @(posedge clk) disable iff (!rst_n_i) xr_ack_o |=> !xr_ack_o
    );

    a_copp_ack_pulse: assert property (
        @(posedge clk) disable iff (!rst_n_i) copp_ack_o |=> !copp_ack_o
    );

    // copper priority seen from the host acknowledge
    a_host_yields: assert property (
        @(posedge clk) disable iff (!rst_n_i) $rose(xr_ack_o) |-> !$past(copp_sel_i)
    );

endmodule

`default_nettype wire

/* source/xr_subsystem.sv */
`default_nettype none

module xr_subsystem (
    input  wire logic                    clk,
    input  wire logic                    rst_n_i,
    input  wire logic                    xr_sel_i,
    input  wire xr_pkg::xr_req_t         xr_req_i,
    output      logic                    xr_ack_o,
    output      xr_pkg::word_t           xr_data_o,
    input  wire logic                    copp_sel_i,
    input  wire xr_pkg::copp_wr_t        copp_wr_i,
    output      logic                    copp_ack_o,
    input  wire logic                    vgen_color_sel_i,
    input  wire xr_pkg::vgen_color_req_t vgen_color_addr_i,
    output      xr_pkg::color_pair_t     color_data_o,
    input  wire logic                    vgen_tile_sel_i,
    input  wire xr_pkg::tile_addr_t      vgen_tile_addr_i,
    output      xr_pkg::word_t           tile_data_o,
    input  wire logic                    copp_prog_sel_i,
    input  wire xr_pkg::copp_addr_t      copp_prog_addr_i,
    output      xr_pkg::copp_word_t      copp_prog_data_o,
    output      xr_pkg::xr_cfg_t         cfg_o
);

    import xr_pkg::*;

    // register bus between arbiter and register file
    xreg_bus_t xreg;
    word_t     xreg_data;

    xrmem_arb i_arb (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .xr_sel_i          (xr_sel_i),
        .xr_req_i          (xr_req_i),
        .xr_ack_o          (xr_ack_o),
        .xr_data_o         (xr_data_o),
        .copp_sel_i        (copp_sel_i),
        .copp_wr_i         (copp_wr_i),
        .copp_ack_o        (copp_ack_o),
        .xreg_o            (xreg),
        .xreg_data_i       (xreg_data),
        .vgen_color_sel_i  (vgen_color_sel_i),
        .vgen_color_addr_i (vgen_color_addr_i),
        .color_data_o      (color_data_o),
        .vgen_tile_sel_i   (vgen_tile_sel_i),
        .vgen_tile_addr_i  (vgen_tile_addr_i),
        .tile_data_o       (tile_data_o),
        .copp_prog_sel_i   (copp_prog_sel_i),
        .copp_prog_addr_i  (copp_prog_addr_i),
        .copp_prog_data_o  (copp_prog_data_o)
    );

    xr_config_regs i_config_regs (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .xreg_i      (xreg),
        .xreg_data_o (xreg_data),
        .cfg_o       (cfg_o)
    );

endmodule

`default_nettype wire

/* dv/xr_tb.sv */
`default_nettype none

`include "xr_defines.svh"

module xr_tb;

    import xr_pkg::*;

    localparam int PERIOD   = 4;
    localparam int N_RANDOM = 200;
    localparam int N_RACE   = 40;
    localparam int N_VIDEO  = 300;
    localparam int N_COLOR  = 1 << `XR_COLOR_W;
    localparam int N_TILE   = 1 << (`XR_TILE_W - 1);
    localparam int N_TILE2  = 1 << `XR_TILE2_W;
    localparam int N_COPP   = 1 << `XR_COPP_W;
    localparam int N_FILL   = 2 * N_COLOR + N_TILE + N_TILE2 + 2 * N_COPP + `XR_REGS_N;
    // blocked reads and reset counted as a few extra operations
    localparam int N_OPS    = N_FILL + 3 * N_RANDOM + 4 * N_RACE + N_VIDEO + 32;

    logic            clk;
    logic            rst_n_i;
    logic            xr_sel_i;
    xr_req_t         xr_req_i;
    logic            xr_ack_o;
    word_t           xr_data_o;
    logic            copp_sel_i;
    copp_wr_t        copp_wr_i;
    logic            copp_ack_o;
    logic            vgen_color_sel_i;
    vgen_color_req_t vgen_color_addr_i;
    color_pair_t     color_data_o;
    logic            vgen_tile_sel_i;
    tile_addr_t      vgen_tile_addr_i;
    word_t           tile_data_o;
    logic            copp_prog_sel_i;
    copp_addr_t      copp_prog_addr_i;
    copp_word_t      copp_prog_data_o;
    xr_cfg_t         cfg_o;

    integer seed = 62514;

    // shadow copies of every memory and register
    word_t regs_m      [`XR_REGS_N];
    argb_t color_a_m   [N_COLOR];
    argb_t color_b_m   [N_COLOR];
    word_t tile_m      [N_TILE];
    word_t tile2_m     [N_TILE2];
    word_t copp_even_m [N_COPP];
    word_t copp_odd_m  [N_COPP];

    xr_subsystem i_dut (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .xr_sel_i          (xr_sel_i),
        .xr_req_i          (xr_req_i),
        .xr_ack_o          (xr_ack_o),
        .xr_data_o         (xr_data_o),
        .copp_sel_i        (copp_sel_i),
        .copp_wr_i         (copp_wr_i),
        .copp_ack_o        (copp_ack_o),
        .vgen_color_sel_i  (vgen_color_sel_i),
        .vgen_color_addr_i (vgen_color_addr_i),
        .color_data_o      (color_data_o),
        .vgen_tile_sel_i   (vgen_tile_sel_i),
        .vgen_tile_addr_i  (vgen_tile_addr_i),
        .tile_data_o       (tile_data_o),
        .copp_prog_sel_i   (copp_prog_sel_i),
        .copp_prog_addr_i  (copp_prog_addr_i),
        .copp_prog_data_o  (copp_prog_data_o),
        .cfg_o             (cfg_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(N_OPS * 20 * PERIOD);
        $display("Timeout: the run took longer than its operations allow, a handshake hung");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            $display("Error: time %0t, %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic word_t next_random();
        return word_t'($random(seed));
    endfunction

    function automatic addr_t make_addr(input logic [1:0] region, input int offset);
        return {region, offset[13:0]};
    endfunction

    // decode follows the region map, bank bits and aliasing of the memory map
    function automatic void model_write(input addr_t addr, input word_t data);
        case (addr[15:14])
            `XR_REGION_REGS: begin
                if (addr[`XR_REG_AW-1:0] < `XR_REGS_N) begin
                    regs_m[addr[`XR_REG_AW-1:0]] = data;
                end
            end
            `XR_REGION_TILE: begin
                if (addr[`XR_TILE_W-1]) begin
                    tile2_m[addr[`XR_TILE2_W-1:0]] = data;
                end else begin
                    tile_m[addr[`XR_TILE_W-2:0]] = data;
                end
            end
            `XR_REGION_COLOR: begin
                if (addr[`XR_COLOR_W]) begin
                    color_b_m[addr[`XR_COLOR_W-1:0]] = data;
                end else begin
                    color_a_m[addr[`XR_COLOR_W-1:0]] = data;
                end
            end
            default: begin
                if (addr[0]) begin
                    copp_odd_m[addr[`XR_COPP_W:1]] = data;
                end else begin
                    copp_even_m[addr[`XR_COPP_W:1]] = data;
                end
            end
        endcase
    endfunction

    function automatic word_t model_read(input addr_t addr);
        word_t data;
        data = '0;
        case (addr[15:14])
            `XR_REGION_REGS: begin
                if (addr[`XR_REG_AW-1:0] < `XR_REGS_N) begin
                    data = regs_m[addr[`XR_REG_AW-1:0]];
                end
            end
            `XR_REGION_TILE: begin
                data = addr[`XR_TILE_W-1] ? tile2_m[addr[`XR_TILE2_W-1:0]]
                                          : tile_m[addr[`XR_TILE_W-2:0]];
            end
            `XR_REGION_COLOR: begin
                data = addr[`XR_COLOR_W] ? color_b_m[addr[`XR_COLOR_W-1:0]]
                                         : color_a_m[addr[`XR_COLOR_W-1:0]];
            end
            default: begin
                data = addr[0] ? copp_odd_m[addr[`XR_COPP_W:1]]
                               : copp_even_m[addr[`XR_COPP_W:1]];
            end
        endcase
        return data;
    endfunction

    task automatic issue_host(input logic wr, input addr_t addr, input word_t data);
        @(posedge clk);
        xr_sel_i <= 1'b1;
        xr_req_i <= {wr, addr, data};
    endtask

    // request stays held until the acknowledge shows up
    task automatic finish_host(output word_t rdata);
        do @(negedge clk); while (!xr_ack_o);
        rdata = xr_data_o;
        @(posedge clk);
        xr_sel_i <= 1'b0;
    endtask

    task automatic host_write(input addr_t addr, input word_t data);
        word_t unused;
        issue_host(1'b1, addr, data);
        finish_host(unused);
        model_write(addr, data);
    endtask

    task automatic host_read_check(input addr_t addr);
        word_t rdata;
        issue_host(1'b0, addr, '0);
        finish_host(rdata);
        check_value("xr_data_o", model_read(addr), rdata);
    endtask

    task automatic check_cfg();
        logic [127:0] expected;
        for (int i = 0; i < `XR_REGS_N; i++) begin
            expected[i*16 +: 16] = regs_m[i];
        end
        @(negedge clk);
        check_value("cfg_o", expected, cfg_o);
    endtask

    task automatic fill_memories();
        for (int i = 0; i < N_COLOR; i++) begin
            host_write(make_addr(`XR_REGION_COLOR, i), next_random());
            host_write(make_addr(`XR_REGION_COLOR, N_COLOR + i), next_random());
        end
        for (int i = 0; i < N_TILE; i++) begin
            host_write(make_addr(`XR_REGION_TILE, i), next_random());
        end
        for (int i = 0; i < N_TILE2; i++) begin
            host_write(make_addr(`XR_REGION_TILE, N_TILE + i), next_random());
        end
        for (int i = 0; i < 2 * N_COPP; i++) begin
            host_write(make_addr(`XR_REGION_COPP, i), next_random());
        end
        for (int i = 0; i < `XR_REGS_N; i++) begin
            host_write(make_addr(`XR_REGION_REGS, i), next_random());
        end
    endtask

    task automatic copper_host_race(input addr_t caddr, input word_t cdata,
                                    input addr_t haddr, input word_t hdata);
        int   cyc;
        int   copp_cyc;
        int   host_cyc;
        logic drop_copp;
        cyc      = 0;
        copp_cyc = 0;
        host_cyc = 0;
        @(posedge clk);
        copp_sel_i <= 1'b1;
        copp_wr_i  <= {caddr, cdata};
        xr_sel_i   <= 1'b1;
        xr_req_i   <= {1'b1, haddr, hdata};
        while (host_cyc == 0) begin
            @(negedge clk);
            cyc++;
            drop_copp = copp_ack_o;
            if (copp_ack_o) begin
                copp_cyc = cyc;
                model_write(caddr, cdata);
            end
            if (xr_ack_o) begin
                host_cyc = cyc;
                model_write(haddr, hdata);
            end
            @(posedge clk);
            if (drop_copp) begin
                copp_sel_i <= 1'b0;
            end
        end
        xr_sel_i <= 1'b0;
        // copper ack must come strictly before the host ack
        check_value("copp_ack_o", 1'b1, copp_cyc != 0 && copp_cyc < host_cyc);
    endtask

    task automatic video_reads(input int n);
        vgen_color_req_t caddr;
        tile_addr_t      taddr;
        copp_addr_t      paddr;
        color_pair_t     exp_color;
        word_t           exp_tile;
        copp_word_t      exp_prog;
        for (int i = 0; i <= n; i++) begin
            @(posedge clk);
            caddr = next_random();
            taddr = tile_addr_t'(next_random());
            paddr = copp_addr_t'(next_random());
            vgen_color_sel_i  <= (i < n);
            vgen_tile_sel_i   <= (i < n);
            copp_prog_sel_i   <= (i < n);
            vgen_color_addr_i <= caddr;
            vgen_tile_addr_i  <= taddr;
            copp_prog_addr_i  <= paddr;
            @(negedge clk);
            // data here belongs to the address of the previous edge
            if (i > 0) begin
                check_value("color_data_o", exp_color, color_data_o);
                check_value("tile_data_o", exp_tile, tile_data_o);
                check_value("copp_prog_data_o", exp_prog, copp_prog_data_o);
            end
            exp_color.a_data = model_read(make_addr(`XR_REGION_COLOR, caddr.a_addr));
            exp_color.b_data = model_read(make_addr(`XR_REGION_COLOR, N_COLOR + caddr.b_addr));
            exp_tile         = model_read(make_addr(`XR_REGION_TILE, taddr));
            exp_prog = {model_read(make_addr(`XR_REGION_COPP, 2 * paddr)),
                        model_read(make_addr(`XR_REGION_COPP, 2 * paddr + 1))};
        end
    endtask

    task automatic drive_reader_sel(input logic [1:0] region, input logic value);
        case (region)
            `XR_REGION_COLOR: vgen_color_sel_i <= value;
            `XR_REGION_TILE:  vgen_tile_sel_i  <= value;
            default:          copp_prog_sel_i  <= value;
        endcase
    endtask

    task automatic blocked_read(input logic [1:0] region);
        addr_t addr;
        word_t rdata;
        addr = make_addr(region, next_random());
        @(posedge clk);
        drive_reader_sel(region, 1'b1);
        // writes go through while the reader owns the read port
        host_write(addr, next_random());
        issue_host(1'b0, addr, '0);
        repeat (6) begin
            @(negedge clk);
            check_value("xr_ack_o", 1'b0, xr_ack_o);
        end
        @(posedge clk);
        drive_reader_sel(region, 1'b0);
        finish_host(rdata);
        check_value("xr_data_o", model_read(addr), rdata);
    endtask

    initial begin
        addr_t caddr;
        addr_t haddr;
        rst_n_i           = 1'b0;
        // requests held during reset must not be acknowledged
        xr_sel_i          = 1'b1;
        xr_req_i          = '0;
        copp_sel_i        = 1'b1;
        copp_wr_i         = '0;
        vgen_color_sel_i  = 1'b0;
        vgen_color_addr_i = '0;
        vgen_tile_sel_i   = 1'b0;
        vgen_tile_addr_i  = '0;
        copp_prog_sel_i   = 1'b0;
        copp_prog_addr_i  = '0;
        repeat (7) begin
            @(negedge clk);
            check_value("xr_ack_o", 1'b0, xr_ack_o);
            check_value("copp_ack_o", 1'b0, copp_ack_o);
        end
        @(posedge clk);
        rst_n_i    <= 1'b1;
        xr_sel_i   <= 1'b0;
        copp_sel_i <= 1'b0;
        @(negedge clk);
        check_value("xr_ack_o", 1'b0, xr_ack_o);
        check_value("copp_ack_o", 1'b0, copp_ack_o);
        check_value("cfg_o", '0, cfg_o);

        fill_memories();
        check_cfg();

        for (int i = 0; i < N_RANDOM; i++) begin
            haddr = next_random();
            host_write(haddr, next_random());
            host_read_check(haddr);
            host_read_check(next_random());
        end
        check_cfg();

        // every other race targets one address for both writers
        for (int i = 0; i < N_RACE; i++) begin
            caddr = next_random();
            haddr = (i % 2 == 0) ? caddr : next_random();
            copper_host_race(caddr, next_random(), haddr, next_random());
            host_read_check(caddr);
            host_read_check(haddr);
        end
        check_cfg();

        video_reads(N_VIDEO);

        blocked_read(`XR_REGION_COLOR);
        blocked_read(`XR_REGION_TILE);
        blocked_read(`XR_REGION_COPP);
        check_cfg();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+source
source/xr_pkg.sv
source/xr_bram.sv
source/xr_config_regs.sv
source/xrmem_arb.sv
source/xr_subsystem.sv
dv/xr_tb.sv
